/* enqdeq_pkg.sv */
`default_nettype none

package enqdeq_pkg;

  localparam int CH_NUM = 4;

  typedef logic [CH_NUM-1:0] ch_vec_t;
  typedef logic [1:0]        ch_idx_t;
  typedef logic [7:0]        ptr_t;     // Ring pointer and entry count
  typedef logic [57:0]       qaddr_t;   // Byte address bits 63..6
  typedef logic [127:0]      desc_t;
  typedef logic [31:0]       reg_data_t;
  typedef logic [7:0]        reg_addr_t;
  typedef logic [127:0]      beat_t;

  localparam reg_addr_t REG_AVAIL    = 8'h00;
  localparam reg_addr_t REG_ACTIVE   = 8'h04;
  localparam reg_addr_t REG_CH_SEL   = 8'h0C;
  localparam reg_addr_t REG_CTRL     = 8'h10;
  localparam reg_addr_t REG_QUE_INFO = 8'h20;
  localparam reg_addr_t REG_QADDR_LO = 8'h28;
  localparam reg_addr_t REG_QADDR_HI = 8'h2C;

  localparam ptr_t        ENTRY_RESET = 8'd16;
  localparam logic [7:0]  DSC_SIZE    = 8'd64;
  localparam logic [10:0] DWORD_CNT   = 11'd16;
  localparam logic [3:0]  REQ_TYPE_RD = 4'd0;
  localparam logic [3:0]  REQ_TYPE_WR = 4'd1;

  typedef struct packed {
    logic      valid;
    logic      write;
    reg_addr_t addr;
    reg_data_t wdata;
  } reg_req_t;

  // Memory request header filling one full beat
  typedef struct packed {
    logic [23:0] rsvd_hi;    // ECRC, attr, TC, completer ID
    logic [7:0]  tag;
    logic [16:0] rsvd_mid;   // Requester ID, poisoned
    logic [3:0]  req_type;
    logic [10:0] dword_cnt;
    logic [63:0] addr;
  } mem_hdr_t;

  function automatic ch_idx_t onehot_idx(ch_vec_t v);
    ch_idx_t idx;
    idx = '0;
    for (int i = 0; i < CH_NUM; i++) begin
      if (v[i]) idx = ch_idx_t'(i);
    end
    return idx;
  endfunction

  function automatic ptr_t next_ptr(ptr_t p, ptr_t entries);
    ptr_t inc;
    inc = p + 8'd1;
    return (inc == entries) ? '0 : inc;   // Wrap at entry count
  endfunction

  function automatic logic [63:0] slot_addr(qaddr_t base, ptr_t p);
    qaddr_t slot;
    slot = base + qaddr_t'(p);
    return {slot, 6'b0};
  endfunction

  function automatic beat_t mk_hdr(logic [7:0] tag, logic [3:0] req_type, logic [63:0] addr);
    mem_hdr_t h;
    h           = '0;
    h.tag       = tag;
    h.req_type  = req_type;
    h.dword_cnt = DWORD_CNT;
    h.addr      = addr;
    return beat_t'(h);
  endfunction

endpackage

`default_nettype wire

/* enqdeq_rr_arb.sv */
`timescale 1ns/100ps
`default_nettype none

module enqdeq_rr_arb (
  input  logic                user_clk,
  input  logic                reset_n,
  input  enqdeq_pkg::ch_vec_t req,
  input  logic                ack,
  output enqdeq_pkg::ch_vec_t grant
);

  enqdeq_pkg::ch_idx_t last_q;   // Last channel that won

  // Walk backwards so the nearest requester after last_q wins
  always_comb begin
    int idx;
    grant = '0;
    for (int k = enqdeq_pkg::CH_NUM; k >= 1; k--) begin
      idx = (int'(last_q) + k) % enqdeq_pkg::CH_NUM;
      if (req[idx]) grant = enqdeq_pkg::ch_vec_t'(1) << idx;
    end
  end

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      last_q <= enqdeq_pkg::ch_idx_t'(enqdeq_pkg::CH_NUM - 1);   // Channel 0 goes first
    end else if (ack) begin
      last_q <= enqdeq_pkg::onehot_idx(grant);
    end
  end

  // Engines only acknowledge a real grant
  a_grant_onehot : assert property (@(posedge user_clk) disable iff (!reset_n)
    $onehot0(grant) && (!ack || grant != '0));

endmodule

`default_nettype wire

/* enqdeq_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module enqdeq_regs (
  input  logic                  user_clk,
  input  logic                  reset_n,
  input  enqdeq_pkg::reg_req_t  reg_req,
  input  enqdeq_pkg::ch_vec_t   rd_busy,
  input  enqdeq_pkg::ch_vec_t   wr_busy,
  input  enqdeq_pkg::ptr_t      rp [enqdeq_pkg::CH_NUM],
  input  enqdeq_pkg::ptr_t      wp [enqdeq_pkg::CH_NUM],
  output enqdeq_pkg::reg_data_t reg_rdata,
  output enqdeq_pkg::ch_vec_t   ch_oe,
  output enqdeq_pkg::ch_vec_t   dscq_clr,
  output enqdeq_pkg::ptr_t      que_entry [enqdeq_pkg::CH_NUM],
  output enqdeq_pkg::qaddr_t    que_addr [enqdeq_pkg::CH_NUM]
);

  logic                  reg_wr;
  logic                  reg_rd;
  logic                  clr_wr;
  enqdeq_pkg::ch_idx_t   ch_sel;
  enqdeq_pkg::ch_vec_t   ch_ie;
  enqdeq_pkg::ch_vec_t   ch_busy;
  enqdeq_pkg::reg_data_t rdata_nxt;

  assign reg_wr  = reg_req.valid & reg_req.write;
  assign reg_rd  = reg_req.valid & ~reg_req.write;
  assign clr_wr  = reg_wr && (reg_req.addr == enqdeq_pkg::REG_CTRL) && reg_req.wdata[2];
  assign ch_busy = rd_busy | wr_busy;

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      ch_sel <= '0;
      ch_ie  <= '0;
      ch_oe  <= '0;
      for (int i = 0; i < enqdeq_pkg::CH_NUM; i++) begin
        que_entry[i] <= enqdeq_pkg::ENTRY_RESET;
        que_addr[i]  <= '0;
      end
    end else if (reg_wr) begin
      case (reg_req.addr)
        enqdeq_pkg::REG_CH_SEL:   ch_sel <= enqdeq_pkg::ch_idx_t'(reg_req.wdata);
        enqdeq_pkg::REG_CTRL: begin
          ch_ie[ch_sel] <= reg_req.wdata[0];
          ch_oe[ch_sel] <= reg_req.wdata[1];
        end
        enqdeq_pkg::REG_QUE_INFO: que_entry[ch_sel] <= reg_req.wdata[15:8];
        enqdeq_pkg::REG_QADDR_LO: que_addr[ch_sel][25:0] <= reg_req.wdata[31:6];
        enqdeq_pkg::REG_QADDR_HI: que_addr[ch_sel][57:26] <= reg_req.wdata;
        default: ;
      endcase
    end
  end

  // Clear stays pending until both engines let go of the channel
  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      dscq_clr <= '0;
    end else begin
      for (int i = 0; i < enqdeq_pkg::CH_NUM; i++) begin
        if (clr_wr && (ch_sel == enqdeq_pkg::ch_idx_t'(i))) begin
          dscq_clr[i] <= 1'b1;
        end else if (!ch_busy[i]) begin
          dscq_clr[i] <= 1'b0;
        end
      end
    end
  end

  always_comb begin
    case (reg_req.addr)
      enqdeq_pkg::REG_AVAIL:    rdata_nxt = enqdeq_pkg::reg_data_t'({enqdeq_pkg::CH_NUM{1'b1}});
      enqdeq_pkg::REG_ACTIVE:   rdata_nxt = enqdeq_pkg::reg_data_t'(ch_ie & ch_oe);
      enqdeq_pkg::REG_CH_SEL:   rdata_nxt = enqdeq_pkg::reg_data_t'(ch_sel);
      enqdeq_pkg::REG_CTRL:
        rdata_nxt = {28'b0, ch_busy[ch_sel], dscq_clr[ch_sel], ch_oe[ch_sel], ch_ie[ch_sel]};
      enqdeq_pkg::REG_QUE_INFO:
        rdata_nxt = {rp[ch_sel], wp[ch_sel], que_entry[ch_sel], enqdeq_pkg::DSC_SIZE};
      enqdeq_pkg::REG_QADDR_LO: rdata_nxt = {que_addr[ch_sel][25:0], 6'b0};
      enqdeq_pkg::REG_QADDR_HI: rdata_nxt = que_addr[ch_sel][57:26];
      default:                  rdata_nxt = '0;
    endcase
  end

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      reg_rdata <= '0;
    end else begin
      reg_rdata <= reg_rd ? rdata_nxt : '0;   // Zero outside a read response
    end
  end

  // Engines hold both ring pointers at slot 0 while a clear is pending
  for (genvar i = 0; i < enqdeq_pkg::CH_NUM; i++) begin : g_clr_ptr
    a_clr_ptr_zero : assert property (@(posedge user_clk) disable iff (!reset_n)
      dscq_clr[i] |=> rp[i] == '0 && wp[i] == '0);
  end

endmodule

`default_nettype wire

/* enqdeq_deq.sv */
`timescale 1ns/100ps
`default_nettype none

module enqdeq_deq (
  input  logic                user_clk,
  input  logic                reset_n,
  input  enqdeq_pkg::ch_vec_t que_rd_req,
  input  enqdeq_pkg::ch_vec_t ch_oe,
  input  enqdeq_pkg::ch_vec_t dscq_clr,
  input  enqdeq_pkg::ptr_t    que_entry [enqdeq_pkg::CH_NUM],
  input  enqdeq_pkg::qaddr_t  que_addr [enqdeq_pkg::CH_NUM],
  input  logic                cpl_valid,
  input  enqdeq_pkg::ch_idx_t cpl_tag,
  input  enqdeq_pkg::desc_t   cpl_data,
  input  logic                rd_ready,
  output enqdeq_pkg::ch_vec_t que_rd_dv,
  output enqdeq_pkg::desc_t   que_rd_dt,
  output logic                rd_valid,
  output enqdeq_pkg::beat_t   rd_data,
  output enqdeq_pkg::ch_vec_t rd_busy,
  output enqdeq_pkg::ptr_t    rp [enqdeq_pkg::CH_NUM]
);

  enqdeq_pkg::ch_vec_t elig;
  enqdeq_pkg::ch_vec_t grant;
  enqdeq_pkg::ch_vec_t cpl_hit;
  enqdeq_pkg::ch_idx_t gidx;
  enqdeq_pkg::desc_t   cpl_data_q;
  logic                take;
  logic                iss_q;   // Header issued last cycle

  assign elig = que_rd_req & ch_oe & ~rd_busy & ~dscq_clr;
  assign take = (|grant) & ~rd_valid & ~iss_q;
  assign gidx = enqdeq_pkg::onehot_idx(grant);

  enqdeq_rr_arb i_rd_arb (
    .user_clk (user_clk),
    .reset_n  (reset_n),
    .req      (elig),
    .ack      (take),
    .grant    (grant)
  );

  // Completion only counts for a channel that is waiting
  always_comb begin
    for (int i = 0; i < enqdeq_pkg::CH_NUM; i++) begin
      cpl_hit[i] = cpl_valid && (cpl_tag == enqdeq_pkg::ch_idx_t'(i)) && rd_busy[i];
    end
  end

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      rd_valid  <= 1'b0;
      iss_q     <= 1'b0;
      rd_busy   <= '0;
      que_rd_dv <= '0;
      for (int i = 0; i < enqdeq_pkg::CH_NUM; i++) begin
        rp[i] <= '0;
      end
    end else begin
      iss_q <= take;
      if (take) begin
        rd_valid <= 1'b1;
      end else if (rd_ready) begin
        rd_valid <= 1'b0;
      end
      rd_busy   <= (grant & {enqdeq_pkg::CH_NUM{take}}) | (rd_busy & ~cpl_hit);
      que_rd_dv <= cpl_hit;
      for (int i = 0; i < enqdeq_pkg::CH_NUM; i++) begin
        if (dscq_clr[i]) begin
          rp[i] <= '0;
        end else if (cpl_hit[i]) begin
          rp[i] <= enqdeq_pkg::next_ptr(rp[i], que_entry[i]);
        end
      end
    end
  end

  always_ff @(posedge user_clk) begin
    if (take) begin
      rd_data <= enqdeq_pkg::mk_hdr(8'(gidx), enqdeq_pkg::REQ_TYPE_RD,
                                    enqdeq_pkg::slot_addr(que_addr[gidx], rp[gidx]));
    end
    if (cpl_valid) begin
      cpl_data_q <= cpl_data;
    end
  end

  assign que_rd_dt = cpl_data_q;

  a_rd_hold : assert property (@(posedge user_clk) disable iff (!reset_n)
    rd_valid && !rd_ready |=> rd_valid && $stable(rd_data));

endmodule

`default_nettype wire

/* enqdeq_enq.sv */
`timescale 1ns/100ps
`default_nettype none

module enqdeq_enq (
  input  logic                user_clk,
  input  logic                reset_n,
  input  enqdeq_pkg::ch_vec_t que_wt_req,
  input  enqdeq_pkg::ch_vec_t dscq_clr,
  input  enqdeq_pkg::desc_t   que_wt_dt [enqdeq_pkg::CH_NUM],
  input  enqdeq_pkg::ptr_t    que_entry [enqdeq_pkg::CH_NUM],
  input  enqdeq_pkg::qaddr_t  que_addr [enqdeq_pkg::CH_NUM],
  input  logic                wr_ready,
  output enqdeq_pkg::ch_vec_t que_wt_ack,
  output logic                wr_valid,
  output logic                wr_last,
  output enqdeq_pkg::beat_t   wr_data,
  output enqdeq_pkg::ch_vec_t wr_busy,
  output enqdeq_pkg::ptr_t    wp [enqdeq_pkg::CH_NUM]
);

  typedef enum logic [1:0] {ENQ_IDLE, ENQ_HDR, ENQ_DATA} enq_state_t;

  enq_state_t          state;
  enqdeq_pkg::ch_vec_t elig;
  enqdeq_pkg::ch_vec_t grant;
  enqdeq_pkg::ch_vec_t sel_q;    // Channel of the transaction in flight
  enqdeq_pkg::ch_idx_t gidx;
  enqdeq_pkg::desc_t   desc_q;
  logic                take;

  assign elig     = que_wt_req & ~wr_busy & ~dscq_clr;   // oe is not checked here
  assign take     = (|grant) & (state == ENQ_IDLE);
  assign gidx     = enqdeq_pkg::onehot_idx(grant);
  assign wr_valid = (state != ENQ_IDLE);
  assign wr_last  = (state == ENQ_DATA);

  enqdeq_rr_arb i_wr_arb (
    .user_clk (user_clk),
    .reset_n  (reset_n),
    .req      (elig),
    .ack      (take),
    .grant    (grant)
  );

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      state      <= ENQ_IDLE;
      sel_q      <= '0;
      que_wt_ack <= '0;
      wr_busy    <= '0;
      for (int i = 0; i < enqdeq_pkg::CH_NUM; i++) begin
        wp[i] <= '0;
      end
    end else begin
      que_wt_ack <= '0;
      case (state)
        ENQ_IDLE: if (take) begin
          state <= ENQ_HDR;
          sel_q <= grant;
        end
        ENQ_HDR:  if (wr_ready) state <= ENQ_DATA;
        ENQ_DATA: if (wr_ready) begin
          state      <= ENQ_IDLE;
          que_wt_ack <= sel_q;
        end
        default:  state <= ENQ_IDLE;
      endcase
      wr_busy <= (grant & {enqdeq_pkg::CH_NUM{take}}) | (wr_busy & ~que_wt_ack);
      for (int i = 0; i < enqdeq_pkg::CH_NUM; i++) begin
        if (dscq_clr[i]) begin
          wp[i] <= '0;
        end else if (take && grant[i]) begin
          wp[i] <= enqdeq_pkg::next_ptr(wp[i], que_entry[i]);   // Advance at grant
        end
      end
    end
  end

  // Header first, then the captured descriptor once the header is taken
  always_ff @(posedge user_clk) begin
    if (take) begin
      wr_data <= enqdeq_pkg::mk_hdr(8'h00, enqdeq_pkg::REQ_TYPE_WR,
                                    enqdeq_pkg::slot_addr(que_addr[gidx], wp[gidx]));
      desc_q  <= que_wt_dt[gidx];
    end else if (state == ENQ_HDR && wr_ready) begin
      wr_data <= desc_q;
    end
  end

  a_wr_hold : assert property (@(posedge user_clk) disable iff (!reset_n)
    wr_valid && !wr_ready |=> wr_valid && $stable(wr_data) && $stable(wr_last));

  a_ack_busy : assert property (@(posedge user_clk) disable iff (!reset_n)
    (que_wt_ack & ~wr_busy) == '0);

endmodule

`default_nettype wire

/* enqdeq_top.sv */
`timescale 1ns/100ps
`default_nettype none

module enqdeq_top (
  input  logic                  user_clk,
  input  logic                  reset_n,
  input  enqdeq_pkg::reg_req_t  reg_req,
  output enqdeq_pkg::reg_data_t reg_rdata,
  input  enqdeq_pkg::ch_vec_t   que_rd_req,
  output enqdeq_pkg::ch_vec_t   que_rd_dv,
  output enqdeq_pkg::desc_t     que_rd_dt,
  output logic                  rd_valid,
  output enqdeq_pkg::beat_t     rd_data,
  input  logic                  rd_ready,
  input  logic                  cpl_valid,
  input  enqdeq_pkg::ch_idx_t   cpl_tag,
  input  enqdeq_pkg::desc_t     cpl_data,
  input  enqdeq_pkg::ch_vec_t   que_wt_req,
  input  enqdeq_pkg::desc_t     que_wt_dt [enqdeq_pkg::CH_NUM],
  output enqdeq_pkg::ch_vec_t   que_wt_ack,
  output logic                  wr_valid,
  output logic                  wr_last,
  output enqdeq_pkg::beat_t     wr_data,
  input  logic                  wr_ready
);

  enqdeq_pkg::ch_vec_t ch_oe;
  enqdeq_pkg::ch_vec_t dscq_clr;
  enqdeq_pkg::ch_vec_t rd_busy;
  enqdeq_pkg::ch_vec_t wr_busy;
  enqdeq_pkg::ptr_t    que_entry [enqdeq_pkg::CH_NUM];
  enqdeq_pkg::qaddr_t  que_addr [enqdeq_pkg::CH_NUM];
  enqdeq_pkg::ptr_t    rp [enqdeq_pkg::CH_NUM];
  enqdeq_pkg::ptr_t    wp [enqdeq_pkg::CH_NUM];

  enqdeq_regs i_regs (
    .user_clk  (user_clk),
    .reset_n   (reset_n),
    .reg_req   (reg_req),
    .rd_busy   (rd_busy),
    .wr_busy   (wr_busy),
    .rp        (rp),
    .wp        (wp),
    .reg_rdata (reg_rdata),
    .ch_oe     (ch_oe),
    .dscq_clr  (dscq_clr),
    .que_entry (que_entry),
    .que_addr  (que_addr)
  );

  enqdeq_deq i_deq (
    .user_clk   (user_clk),
    .reset_n    (reset_n),
    .que_rd_req (que_rd_req),
    .ch_oe      (ch_oe),
    .dscq_clr   (dscq_clr),
    .que_entry  (que_entry),
    .que_addr   (que_addr),
    .cpl_valid  (cpl_valid),
    .cpl_tag    (cpl_tag),
    .cpl_data   (cpl_data),
    .rd_ready   (rd_ready),
    .que_rd_dv  (que_rd_dv),
    .que_rd_dt  (que_rd_dt),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data),
    .rd_busy    (rd_busy),
    .rp         (rp)
  );

  enqdeq_enq i_enq (
    .user_clk   (user_clk),
    .reset_n    (reset_n),
    .que_wt_req (que_wt_req),
    .dscq_clr   (dscq_clr),
    .que_wt_dt  (que_wt_dt),
    .que_entry  (que_entry),
    .que_addr   (que_addr),
    .wr_ready   (wr_ready),
    .que_wt_ack (que_wt_ack),
    .wr_valid   (wr_valid),
    .wr_last    (wr_last),
    .wr_data    (wr_data),
    .wr_busy    (wr_busy),
    .wp         (wp)
  );

endmodule

`default_nettype wire

/* tb_enqdeq.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_enqdeq;

  localparam int TIMEOUT_CYCLES = 200;

  logic                  user_clk;
  logic                  reset_n;
  enqdeq_pkg::reg_req_t  reg_req;
  enqdeq_pkg::reg_data_t reg_rdata;
  enqdeq_pkg::ch_vec_t   que_rd_req;
  enqdeq_pkg::ch_vec_t   que_rd_dv;
  enqdeq_pkg::desc_t     que_rd_dt;
  logic                  rd_valid;
  enqdeq_pkg::beat_t     rd_data;
  logic                  rd_ready;
  logic                  cpl_valid;
  enqdeq_pkg::ch_idx_t   cpl_tag;
  enqdeq_pkg::desc_t     cpl_data;
  enqdeq_pkg::ch_vec_t   que_wt_req;
  enqdeq_pkg::desc_t     que_wt_dt [enqdeq_pkg::CH_NUM];
  enqdeq_pkg::ch_vec_t   que_wt_ack;
  logic                  wr_valid;
  logic                  wr_last;
  enqdeq_pkg::beat_t     wr_data;
  logic                  wr_ready;

  logic [31:0]      rng_state;
  string            cur_test;
  int               err_count;
  int               test_count;
  int               fail_tests;
  logic [63:0]      base_tb [enqdeq_pkg::CH_NUM];     // Byte address of slot 0
  enqdeq_pkg::ptr_t entries_tb [enqdeq_pkg::CH_NUM];

  enqdeq_top i_enqdeq_top (
    .user_clk   (user_clk),
    .reset_n    (reset_n),
    .reg_req    (reg_req),
    .reg_rdata  (reg_rdata),
    .que_rd_req (que_rd_req),
    .que_rd_dv  (que_rd_dv),
    .que_rd_dt  (que_rd_dt),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data),
    .rd_ready   (rd_ready),
    .cpl_valid  (cpl_valid),
    .cpl_tag    (cpl_tag),
    .cpl_data   (cpl_data),
    .que_wt_req (que_wt_req),
    .que_wt_dt  (que_wt_dt),
    .que_wt_ack (que_wt_ack),
    .wr_valid   (wr_valid),
    .wr_last    (wr_last),
    .wr_data    (wr_data),
    .wr_ready   (wr_ready)
  );

  initial begin
    user_clk = 1'b0;
    forever #50 user_clk = ~user_clk;
  end

  // Xorshift32
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic rand_ready();
    logic [31:0] r;
    r = next_rand();
    return r[3:0] > 4'd5;
  endfunction

  function automatic enqdeq_pkg::desc_t rand_desc();
    enqdeq_pkg::desc_t d;
    for (int i = 0; i < 4; i++) begin
      d[i*32 +: 32] = next_rand();
    end
    return d;
  endfunction

  task automatic report_mismatch(string what, logic [127:0] exp, logic [127:0] act);
    $display("Error: %s %s expected %0h actual %0h", cur_test, what, exp, act);
    err_count++;
  endtask

  task automatic report_timeout(string what);
    $display("%s: no %s arrived within %0d cycles", cur_test, what, TIMEOUT_CYCLES);
    err_count++;
  endtask

  task automatic end_test(int errs_before);
    test_count++;
    if (err_count == errs_before) begin
      $display("%s: passed", cur_test);
    end else begin
      $display("%s: failed with %0d errors", cur_test, err_count - errs_before);
      fail_tests++;
    end
  endtask

  task automatic reg_write(enqdeq_pkg::reg_addr_t addr, enqdeq_pkg::reg_data_t data);
    @(negedge user_clk);
    reg_req.valid = 1'b1;
    reg_req.write = 1'b1;
    reg_req.addr  = addr;
    reg_req.wdata = data;
    @(negedge user_clk);
    reg_req = '0;
  endtask

  task automatic reg_read(enqdeq_pkg::reg_addr_t addr, output enqdeq_pkg::reg_data_t data);
    @(negedge user_clk);
    reg_req.valid = 1'b1;
    reg_req.write = 1'b0;
    reg_req.addr  = addr;
    reg_req.wdata = '0;
    @(negedge user_clk);
    reg_req = '0;
    data    = reg_rdata;   // Registered response
  endtask

  task automatic setup_channel(int ch, logic [63:0] base, enqdeq_pkg::ptr_t entries,
                               logic [1:0] ctrl);
    reg_write(enqdeq_pkg::REG_CH_SEL, 32'(ch));
    reg_write(enqdeq_pkg::REG_QADDR_LO, base[31:0]);
    reg_write(enqdeq_pkg::REG_QADDR_HI, base[63:32]);
    reg_write(enqdeq_pkg::REG_QUE_INFO, {16'h0, entries, 8'h0});
    reg_write(enqdeq_pkg::REG_CTRL, {30'h0, ctrl});
    base_tb[ch]    = base;
    entries_tb[ch] = entries;
  endtask

  // Memory side of the read stream with ready from the random generator
  task automatic wait_rd_hdr(output enqdeq_pkg::mem_hdr_t hdr);
    int   n;
    logic got;
    n   = 0;
    got = 1'b0;
    hdr = '0;
    while (!got && n < TIMEOUT_CYCLES) begin
      @(negedge user_clk);
      rd_ready = rand_ready();
      if (rd_valid && rd_ready) begin
        hdr = rd_data;
        got = 1'b1;
      end
      n++;
    end
    @(negedge user_clk);
    rd_ready = 1'b0;     // Beat taken at the edge just passed
    if (!got) report_timeout("read request header");
  endtask

  task automatic send_cpl(enqdeq_pkg::ch_idx_t tag, enqdeq_pkg::desc_t data,
                          output enqdeq_pkg::ch_vec_t dv, output enqdeq_pkg::desc_t dt);
    @(negedge user_clk);
    cpl_valid = 1'b1;
    cpl_tag   = tag;
    cpl_data  = data;
    @(negedge user_clk);
    cpl_valid = 1'b0;
    dv        = que_rd_dv;
    dt        = que_rd_dt;
  endtask

  task automatic wait_wr_beat(output enqdeq_pkg::beat_t beat, output logic last);
    int   n;
    logic got;
    n    = 0;
    got  = 1'b0;
    beat = '0;
    last = 1'b0;
    while (!got && n < TIMEOUT_CYCLES) begin
      @(negedge user_clk);
      wr_ready = rand_ready();
      if (wr_valid && wr_ready) begin
        beat = wr_data;
        last = wr_last;
        got  = 1'b1;
      end
      n++;
    end
    if (!got) report_timeout("write request beat");
  endtask

  task automatic wait_wt_ack(output enqdeq_pkg::ch_vec_t ack);
    int n;
    n   = 0;
    ack = '0;
    while (ack == '0 && n < TIMEOUT_CYCLES) begin
      @(negedge user_clk);
      wr_ready = 1'b0;
      ack      = que_wt_ack;
      n++;
    end
    if (ack == '0) report_timeout("store acknowledge");
  endtask

  task automatic reg_access();
    enqdeq_pkg::reg_data_t d;
    int                    errs;
    errs     = err_count;
    cur_test = "reg_access";
    reg_read(enqdeq_pkg::REG_AVAIL, d);
    if (d !== 32'hF) report_mismatch("avail", 128'(32'hF), 128'(d));
    reg_read(enqdeq_pkg::REG_ACTIVE, d);
    if (d !== 32'h0) report_mismatch("active", 128'(32'h0), 128'(d));
    reg_read(enqdeq_pkg::REG_QUE_INFO, d);
    if (d !== {8'd0, 8'd0, 8'd16, 8'd64}) begin
      report_mismatch("que_info", 128'({8'd0, 8'd0, 8'd16, 8'd64}), 128'(d));
    end
    reg_write(enqdeq_pkg::REG_CH_SEL, 32'd3);
    reg_write(enqdeq_pkg::REG_QADDR_LO, 32'h1234_5640);
    reg_write(enqdeq_pkg::REG_QADDR_HI, 32'h89ab_cdef);
    reg_write(enqdeq_pkg::REG_CTRL, 32'h3);
    reg_read(enqdeq_pkg::REG_CH_SEL, d);
    if (d !== 32'd3) report_mismatch("ch_sel", 128'(32'd3), 128'(d));
    reg_read(enqdeq_pkg::REG_QADDR_LO, d);
    if (d !== 32'h1234_5640) report_mismatch("qaddr_lo", 128'(32'h1234_5640), 128'(d));
    reg_read(enqdeq_pkg::REG_QADDR_HI, d);
    if (d !== 32'h89ab_cdef) report_mismatch("qaddr_hi", 128'(32'h89ab_cdef), 128'(d));
    reg_read(enqdeq_pkg::REG_CTRL, d);
    if (d !== 32'h3) report_mismatch("ctrl", 128'(32'h3), 128'(d));
    reg_read(enqdeq_pkg::REG_ACTIVE, d);
    if (d !== 32'h8) report_mismatch("active", 128'(32'h8), 128'(d));
    reg_write(enqdeq_pkg::REG_CTRL, 32'h0);
    end_test(errs);
  endtask

  task automatic fetch_one();
    enqdeq_pkg::mem_hdr_t  hdr;
    enqdeq_pkg::desc_t     desc;
    enqdeq_pkg::desc_t     dt;
    enqdeq_pkg::ch_vec_t   dv;
    enqdeq_pkg::reg_data_t d;
    int                    errs;
    errs     = err_count;
    cur_test = "fetch_one";
    setup_channel(1, 64'h0000_0042_0001_0000, 8'd16, 2'b11);
    que_rd_req[1] = 1'b1;
    wait_rd_hdr(hdr);
    que_rd_req = '0;
    if (hdr.tag !== 8'd1) report_mismatch("tag", 128'(8'd1), 128'(hdr.tag));
    if (hdr.req_type !== 4'd0) report_mismatch("type", 128'(4'd0), 128'(hdr.req_type));
    if (hdr.dword_cnt !== 11'd16) report_mismatch("dwords", 128'(11'd16), 128'(hdr.dword_cnt));
    if (hdr.addr !== base_tb[1]) report_mismatch("address", 128'(base_tb[1]), 128'(hdr.addr));
    desc = rand_desc();
    send_cpl(2'd1, desc, dv, dt);
    if (dv !== 4'b0010) report_mismatch("dv", 128'(4'b0010), 128'(dv));
    if (dt !== desc) report_mismatch("data", desc, dt);
    reg_read(enqdeq_pkg::REG_QUE_INFO, d);
    if (d[31:24] !== 8'd1) report_mismatch("rp", 128'(8'd1), 128'(d[31:24]));
    end_test(errs);
  endtask

  task automatic fetch_wrap_and_share();
    enqdeq_pkg::mem_hdr_t hdr;
    enqdeq_pkg::desc_t    desc;
    enqdeq_pkg::desc_t    dt;
    enqdeq_pkg::ch_vec_t  dv;
    logic [63:0]          exp_addr;
    int                   ch;
    int                   errs;
    errs     = err_count;
    cur_test = "fetch_wrap_and_share";
    setup_channel(0, 64'h0000_0000_0020_0000, 8'd2, 2'b11);
    setup_channel(2, 64'h0000_0001_0040_0000, 8'd2, 2'b11);
    que_rd_req = 4'b0101;
    for (int r = 0; r < 3; r++) begin
      for (int k = 0; k < 2; k++) begin
        ch = (k == 0) ? 2 : 0;   // Arbiter last served channel 1
        wait_rd_hdr(hdr);
        exp_addr = base_tb[ch] + 64'(r % 2) * 64'd64;
        if (hdr.tag !== 8'(ch)) report_mismatch("tag", 128'(8'(ch)), 128'(hdr.tag));
        if (hdr.addr !== exp_addr) report_mismatch("address", 128'(exp_addr), 128'(hdr.addr));
      end
      if (r == 2) que_rd_req = '0;
      if (r == 0) begin
        send_cpl(2'd1, rand_desc(), dv, dt);   // Channel 1 has nothing outstanding
        if (dv !== 4'b0000) report_mismatch("foreign dv", 128'(4'b0000), 128'(dv));
      end
      for (int k = 0; k < 2; k++) begin
        ch   = (k == 0) ? 2 : 0;
        desc = rand_desc();
        send_cpl(enqdeq_pkg::ch_idx_t'(ch), desc, dv, dt);
        if (dv !== (4'b0001 << ch)) report_mismatch("dv", 128'(4'b0001 << ch), 128'(dv));
        if (dt !== desc) report_mismatch("data", desc, dt);
      end
    end
    end_test(errs);
  endtask

  task automatic store_backpressure();
    enqdeq_pkg::mem_hdr_t  hdr;
    enqdeq_pkg::beat_t     beat;
    enqdeq_pkg::desc_t     exp_desc;
    enqdeq_pkg::ch_vec_t   ack;
    enqdeq_pkg::ptr_t      wp_exp [enqdeq_pkg::CH_NUM];
    enqdeq_pkg::reg_data_t d;
    logic                  last;
    logic [63:0]           exp_addr;
    int                    ch;
    int                    errs;
    errs     = err_count;
    cur_test = "store_backpressure";
    setup_channel(3, 64'h0000_0003_0080_0000, 8'd16, 2'b11);
    for (int i = 0; i < enqdeq_pkg::CH_NUM; i++) begin
      wp_exp[i] = 8'd0;
    end
    que_wt_dt[0] = rand_desc();
    que_wt_dt[3] = rand_desc();
    que_wt_req   = 4'b1001;
    for (int i = 0; i < 6; i++) begin
      ch       = (i % 2 == 0) ? 0 : 3;
      exp_desc = que_wt_dt[ch];
      exp_addr = base_tb[ch] + 64'(wp_exp[ch]) * 64'd64;
      wait_wr_beat(beat, last);
      hdr = beat;
      if (last !== 1'b0) report_mismatch("header last", 128'(1'b0), 128'(last));
      if (hdr.tag !== 8'd0) report_mismatch("tag", 128'(8'd0), 128'(hdr.tag));
      if (hdr.req_type !== 4'd1) report_mismatch("type", 128'(4'd1), 128'(hdr.req_type));
      if (hdr.addr !== exp_addr) report_mismatch("address", 128'(exp_addr), 128'(hdr.addr));
      wp_exp[ch] = (wp_exp[ch] + 8'd1 == entries_tb[ch]) ? 8'd0 : wp_exp[ch] + 8'd1;
      wait_wr_beat(beat, last);
      if (beat !== exp_desc) report_mismatch("data", exp_desc, beat);
      if (last !== 1'b1) report_mismatch("data last", 128'(1'b1), 128'(last));
      wait_wt_ack(ack);
      if (ack !== (4'b0001 << ch)) report_mismatch("ack", 128'(4'b0001 << ch), 128'(ack));
      que_wt_dt[ch] = rand_desc();   // Next descriptor of that channel
      if (i == 5) que_wt_req = '0;
    end
    reg_write(enqdeq_pkg::REG_CH_SEL, 32'd0);
    reg_read(enqdeq_pkg::REG_QUE_INFO, d);
    if (d[23:16] !== wp_exp[0]) report_mismatch("wp ch0", 128'(wp_exp[0]), 128'(d[23:16]));
    reg_write(enqdeq_pkg::REG_CH_SEL, 32'd3);
    reg_read(enqdeq_pkg::REG_QUE_INFO, d);
    if (d[23:16] !== wp_exp[3]) report_mismatch("wp ch3", 128'(wp_exp[3]), 128'(d[23:16]));
    end_test(errs);
  endtask

  task automatic channel_clear();
    enqdeq_pkg::mem_hdr_t  hdr;
    enqdeq_pkg::beat_t     beat;
    enqdeq_pkg::desc_t     dt;
    enqdeq_pkg::ch_vec_t   dv;
    enqdeq_pkg::ch_vec_t   ack;
    enqdeq_pkg::reg_data_t d;
    logic                  last;
    int                    errs;
    errs     = err_count;
    cur_test = "channel_clear";
    que_rd_req[1] = 1'b1;
    wait_rd_hdr(hdr);
    que_rd_req = '0;
    send_cpl(2'd1, rand_desc(), dv, dt);
    que_wt_dt[1] = rand_desc();
    que_wt_req   = 4'b0010;
    wait_wr_beat(beat, last);
    wait_wr_beat(beat, last);
    wait_wt_ack(ack);
    que_wt_req = '0;
    reg_write(enqdeq_pkg::REG_CH_SEL, 32'd1);
    reg_read(enqdeq_pkg::REG_QUE_INFO, d);
    if (d[31:16] !== 16'h0201) report_mismatch("rp/wp before", 128'(16'h0201), 128'(d[31:16]));
    que_rd_req[1] = 1'b1;
    wait_rd_hdr(hdr);   // Left outstanding so the clear has to wait
    que_rd_req = '0;
    reg_write(enqdeq_pkg::REG_CTRL, 32'h7);
    reg_read(enqdeq_pkg::REG_CTRL, d);
    if (d !== 32'hF) report_mismatch("ctrl pending", 128'(32'hF), 128'(d));
    send_cpl(2'd1, rand_desc(), dv, dt);
    reg_read(enqdeq_pkg::REG_CTRL, d);
    if (d !== 32'h3) report_mismatch("ctrl done", 128'(32'h3), 128'(d));
    reg_read(enqdeq_pkg::REG_QUE_INFO, d);
    if (d[31:16] !== 16'h0000) report_mismatch("rp/wp after", 128'(16'h0000), 128'(d[31:16]));
    que_rd_req[1] = 1'b1;
    wait_rd_hdr(hdr);
    que_rd_req = '0;
    if (hdr.addr !== base_tb[1]) report_mismatch("address", 128'(base_tb[1]), 128'(hdr.addr));
    send_cpl(2'd1, rand_desc(), dv, dt);
    end_test(errs);
  endtask

  initial begin
    rng_state  = 32'hace8ab07;
    err_count  = 0;
    test_count = 0;
    fail_tests = 0;
    reset_n    = 1'b0;
    reg_req    = '0;
    que_rd_req = '0;
    rd_ready   = 1'b0;
    cpl_valid  = 1'b0;
    cpl_tag    = '0;
    cpl_data   = '0;
    que_wt_req = '0;
    wr_ready   = 1'b0;
    for (int i = 0; i < enqdeq_pkg::CH_NUM; i++) begin
      que_wt_dt[i] = '0;
    end
    repeat (3) @(negedge user_clk);
    reset_n = 1'b1;
    reg_access();
    fetch_one();
    fetch_wrap_and_share();
    store_backpressure();
    channel_clear();
    $display("Summary: %0d tests, %0d failed, %0d errors", test_count, fail_tests, err_count);
    if (err_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
enqdeq_pkg.sv
enqdeq_rr_arb.sv
enqdeq_regs.sv
enqdeq_deq.sv
enqdeq_enq.sv
enqdeq_top.sv
tb_enqdeq.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the enqdeq testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -j 0 --top-module tb_enqdeq \
    -f flist.f -o sim_enqdeq; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/sim_enqdeq > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error"
  exit 1
fi

cat "$LOG"

if grep -q "Test completed successfully" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
